// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module mshr_file_tb \
		-f mshr_file.f --Mdir obj_dir -o mshr_file_sim
	./obj_dir/mshr_file_sim +verilator+error+limit+100 > sim.log 2>&1; cat sim.log
	grep -q "^TESTBENCH PASSED$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== mshr_file.f ====
verilog/mshr_pkg.sv
verilog/fixed_arbiter.sv
verilog/store_data_queue.sv
verilog/mshr_alloc_ctrl.sv
verilog/mshr_entry.sv
verilog/mshr_file.sv
verif/mshr_file_checker.sv
verif/mshr_file_tb.sv

// ==== verif/mshr_file_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mshr_file_checker (
  input wire logic               clock,
  input wire logic               reset,
  input wire logic               acquire_valid,
  input wire mshr_pkg::acquire_t acquire,
  input wire logic               acquire_ready,
  input wire logic               replay_valid,
  input wire mshr_pkg::replay_t  replay,
  input wire logic               replay_ready
);

  int fail_count = 0;  // Polled by the testbench

  valid_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown({acquire_valid, replay_valid}))
    else begin
      fail_count++;
      $error("acquire_valid or replay_valid is unknown");
    end

  replay_stable: assert property (@(posedge clock) disable iff (reset)
    replay_valid && !replay_ready |=> replay_valid && $stable(replay))
    else begin
      fail_count++;
      $error("replay changed while stalled");
    end

  acquire_stable: assert property (@(posedge clock) disable iff (reset)
    acquire_valid && !acquire_ready |=> acquire_valid && $stable(acquire))
    else begin
      fail_count++;
      $error("acquire changed while stalled");
    end

endmodule

`default_nettype wire

// ==== verif/mshr_file_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mshr_file_tb;

  localparam int NUM_REQS   = 60;
  localparam int MAX_CYCLES = 40 * NUM_REQS + 100;
  localparam int OFF        = mshr_pkg::BLOCK_OFF_BITS;

  logic clock;
  logic reset;
  logic req_valid;
  mshr_pkg::mem_req_t req;
  logic req_ready;
  logic block_hit;
  logic set_conflict;
  logic acquire_valid;
  mshr_pkg::acquire_t acquire;
  logic acquire_ready;
  logic grant_valid;
  mshr_pkg::mshr_id_t grant_id;
  logic replay_valid;
  mshr_pkg::replay_t replay;
  logic replay_ready;

  int seed;
  int cycles;
  int accepted;
  logic busy [mshr_pkg::NUM_MSHRS];
  logic [mshr_pkg::BLOCK_W-1:0] blk_addr [mshr_pkg::NUM_MSHRS];
  logic acquired [mshr_pkg::NUM_MSHRS];
  logic granted [mshr_pkg::NUM_MSHRS];
  int grant_wait [mshr_pkg::NUM_MSHRS];  // Cycles until the grant or -1
  mshr_pkg::mem_req_t pending [mshr_pkg::NUM_MSHRS][$];

  mshr_file UUT (
    .clock         (clock),
    .reset         (reset),
    .req_valid     (req_valid),
    .req           (req),
    .req_ready     (req_ready),
    .block_hit     (block_hit),
    .set_conflict  (set_conflict),
    .acquire_valid (acquire_valid),
    .acquire       (acquire),
    .acquire_ready (acquire_ready),
    .grant_valid   (grant_valid),
    .grant_id      (grant_id),
    .replay_valid  (replay_valid),
    .replay        (replay),
    .replay_ready  (replay_ready)
  );

  bind mshr_file mshr_file_checker u_checker (
    .clock         (clock),
    .reset         (reset),
    .acquire_valid (acquire_valid),
    .acquire       (acquire),
    .acquire_ready (acquire_ready),
    .replay_valid  (replay_valid),
    .replay        (replay),
    .replay_ready  (replay_ready)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  task automatic stop_with_failure();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(string name, logic [63:0] got, logic [63:0] exp);
    $display("Mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    stop_with_failure();
  endtask

  task automatic report_failure(string what);
    $display("Error: %s", what);
    stop_with_failure();
  endtask

  function automatic logic is_cacheable(logic [31:0] addr);
    return (addr >= 32'h1000_0000 && addr < 32'h1100_0000) ||
           (addr >= 32'h8000_0000 && addr < 32'h9000_0000);
  endfunction

  function automatic logic any_outstanding();
    logic found;
    found = 1'b0;
    for (int k = 0; k < mshr_pkg::NUM_MSHRS; k++) found |= busy[k];
    return found;
  endfunction

  function automatic mshr_pkg::mem_req_t random_req();
    mshr_pkg::mem_req_t r;
    logic [31:0] base;
    int unsigned idx;
    case ($random(seed) & 3)
      0:       base = 32'h1000_0000;
      1:       base = 32'h8000_0000;
      2:       base = 32'h1000_1000;  // Same indices, other tag
      default: base = 32'h4000_0000;  // Uncacheable
    endcase
    idx = $unsigned($random(seed)) % 5;
    r.addr     = base + (idx << OFF) + ($random(seed) & 32'h38);
    r.is_write = ($random(seed) & 1) != 0;
    r.data     = {$random(seed), $random(seed)};
    r.req_id   = 4'($random(seed));
    return r;
  endfunction

  // Checks the DUT outputs of the ending cycle, updates the model, drives the next cycle
  task automatic run_cycle();
    logic [mshr_pkg::BLOCK_W-1:0] blk;
    logic cacheable;
    logic conflict;
    logic exp_ready;
    int hit_slot;
    int free_slot;
    int nwrites;
    int slot;
    int pick;
    mshr_pkg::mem_req_t head;

    blk       = req.addr[31:OFF];
    cacheable = is_cacheable(req.addr);
    conflict  = 1'b0;
    hit_slot  = -1;
    free_slot = -1;
    nwrites   = 0;
    for (int k = mshr_pkg::NUM_MSHRS - 1; k >= 0; k--) begin
      if (!busy[k]) begin
        free_slot = k;  // Ends on the lowest free
      end else if (blk_addr[k] == blk) begin
        hit_slot = k;
      end else if (blk_addr[k][mshr_pkg::IDX_BITS-1:0] == blk[mshr_pkg::IDX_BITS-1:0]) begin
        conflict = 1'b1;
      end
      for (int j = 0; j < pending[k].size(); j++) nwrites += pending[k][j].is_write;
    end
    exp_ready = cacheable && (!req.is_write || nwrites < mshr_pkg::NUM_SDQ) &&
                ((hit_slot >= 0) ?
                 (!granted[hit_slot] && pending[hit_slot].size() < mshr_pkg::RPQ_DEPTH) :
                 (!conflict && free_slot >= 0));

    assert (cacheable || !req_ready) else report_failure("uncacheable request saw req_ready");
    if (req_valid && cacheable) begin
      assert (block_hit == (hit_slot >= 0))
        else report_mismatch("block_hit", block_hit, hit_slot >= 0);
      assert (set_conflict == conflict) else report_mismatch("set_conflict", set_conflict, conflict);
      assert (!set_conflict || !req_ready) else report_failure("req_ready high on a set conflict");
      assert (req_ready == exp_ready) else report_mismatch("req_ready", req_ready, exp_ready);
    end

    if (acquire_valid && acquire_ready) begin
      slot = acquire.mshr_id;
      assert (busy[slot] && !acquired[slot]) else report_failure("acquire without a new primary");
      assert (acquire.block_addr == blk_addr[slot])
        else report_mismatch("acquire.block_addr", acquire.block_addr, blk_addr[slot]);
      acquired[slot]   = 1'b1;
      grant_wait[slot] = 2 + ($unsigned($random(seed)) % 6);
    end
    if (grant_valid) granted[grant_id] = 1'b1;

    if (replay_valid) begin
      slot = -1;
      for (int k = 0; k < mshr_pkg::NUM_MSHRS; k++) begin
        if (busy[k] && granted[k] && blk_addr[k] == replay.req.addr[31:OFF]) slot = k;
      end
      if (slot < 0) begin
        report_failure("replay for a block without a granted miss");
      end else begin
        head = pending[slot][0];  // Oldest accepted request of the block
        assert (replay.req.addr == head.addr)
          else report_mismatch("replay.addr", replay.req.addr, head.addr);
        assert (replay.req.req_id == head.req_id)
          else report_mismatch("replay.req_id", replay.req.req_id, head.req_id);
        assert (replay.req.is_write == head.is_write)
          else report_mismatch("replay.is_write", replay.req.is_write, head.is_write);
        assert (!head.is_write || replay.data == head.data)
          else report_mismatch("replay.data", replay.data, head.data);
        if (replay_ready) begin
          void'(pending[slot].pop_front());
          if (pending[slot].size() == 0) busy[slot] = 1'b0;
        end
      end
    end

    if (req_valid && req_ready) begin
      accepted++;
      if (hit_slot >= 0) begin
        pending[hit_slot].push_back(req);
      end else begin
        busy[free_slot]     = 1'b1;
        blk_addr[free_slot] = blk;
        acquired[free_slot] = 1'b0;
        granted[free_slot]  = 1'b0;
        pending[free_slot].push_back(req);
      end
    end

    pick = -1;
    for (int k = mshr_pkg::NUM_MSHRS - 1; k >= 0; k--) begin
      if (grant_wait[k] > 0) grant_wait[k]--;
      else if (grant_wait[k] == 0) pick = k;
    end
    if (pick >= 0) grant_wait[pick] = -1;
    grant_valid   <= (pick >= 0);
    grant_id      <= mshr_pkg::mshr_id_t'(pick);
    acquire_ready <= ($random(seed) & 3) != 0;
    replay_ready  <= ($random(seed) & 3) != 0;
    req_valid     <= (accepted < NUM_REQS) && (($random(seed) & 7) != 0);
    req           <= random_req();
  endtask

  initial begin
    seed          = 32'hfc65;
    cycles        = 0;
    accepted      = 0;
    reset         = 1'b1;
    req_valid     = 1'b0;
    req           = '0;
    acquire_ready = 1'b0;
    grant_valid   = 1'b0;
    grant_id      = '0;
    replay_ready  = 1'b0;
    for (int k = 0; k < mshr_pkg::NUM_MSHRS; k++) begin
      busy[k]       = 1'b0;
      blk_addr[k]   = '0;
      acquired[k]   = 1'b0;
      granted[k]    = 1'b0;
      grant_wait[k] = -1;
    end
    repeat (4) @(posedge clock);
    reset <= 1'b0;
    @(posedge clock);
    assert (!acquire_valid && !replay_valid) else report_failure("valid output high after reset");
    while (accepted < NUM_REQS || any_outstanding()) begin
      if (UUT.u_checker.fail_count != 0) report_failure("a checker assertion failed");
      if (cycles > MAX_CYCLES) report_failure($sformatf("timeout after %0d cycles", cycles));
      run_cycle();
      @(posedge clock);
      cycles++;
    end
    @(negedge clock);
    if (UUT.u_checker.fail_count != 0) begin
      report_failure("a checker assertion failed");
    end else begin
      $display("TESTBENCH PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/fixed_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module fixed_arbiter #(
  parameter type payload_t = logic
) (
  input  wire logic                           clock,
  input  wire logic                           reset,
  input  wire logic [mshr_pkg::NUM_MSHRS-1:0] in_valid,
  input  wire payload_t                       in_bits [mshr_pkg::NUM_MSHRS],
  input  wire logic                           out_ready,
  output logic [mshr_pkg::NUM_MSHRS-1:0]      in_ready,
  output logic                                out_valid,
  output payload_t                            out_bits
);

  mshr_pkg::mshr_id_t pick;
  mshr_pkg::mshr_id_t sel;
  mshr_pkg::mshr_id_t held_sel;
  logic held;

  always_comb begin
    pick = '0;
    for (int i = mshr_pkg::NUM_MSHRS - 1; i >= 0; i--) begin
      if (in_valid[i]) begin
        pick = mshr_pkg::mshr_id_t'(i);  // Lowest index wins
      end
    end
  end

  assign sel       = held ? held_sel : pick;  // Stalled winner keeps the output
  assign out_valid = |in_valid;
  assign out_bits  = in_bits[sel];

  always_comb begin
    in_ready      = '0;
    in_ready[sel] = out_valid && out_ready;
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      held     <= 1'b0;
      held_sel <= '0;
    end else begin
      held     <= out_valid && !out_ready;
      held_sel <= sel;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/mshr_alloc_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module mshr_alloc_ctrl (
  input  wire logic                      req_valid,
  input  wire mshr_pkg::mem_req_t        req,
  input  wire mshr_pkg::entry_status_t   status [mshr_pkg::NUM_MSHRS],
  input  wire logic                      sdq_has_free,
  output logic                           req_ready,
  output logic [mshr_pkg::NUM_MSHRS-1:0] pri_alloc,
  output logic [mshr_pkg::NUM_MSHRS-1:0] sec_alloc,
  output logic                           sdq_enq,
  output logic                           block_hit,
  output logic                           set_conflict
);

  logic [mshr_pkg::BLOCK_W-1:0] req_block;
  logic cacheable;
  logic [mshr_pkg::NUM_MSHRS-1:0] free;
  logic [mshr_pkg::NUM_MSHRS-1:0] lowest_free;
  logic [mshr_pkg::NUM_MSHRS-1:0] idx_match;
  logic [mshr_pkg::NUM_MSHRS-1:0] blk_match;
  logic [mshr_pkg::NUM_MSHRS-1:0] sec_open;
  logic sdq_ok;
  logic pri_ok;
  logic sec_ok;
  logic req_fire;

  assign req_block = req.addr[mshr_pkg::ADDR_W-1:mshr_pkg::BLOCK_OFF_BITS];
  assign cacheable = ((req.addr & mshr_pkg::CACHE_MASK_0) == mshr_pkg::CACHE_BASE_0) ||
                     ((req.addr & mshr_pkg::CACHE_MASK_1) == mshr_pkg::CACHE_BASE_1);

  always_comb begin
    for (int i = 0; i < mshr_pkg::NUM_MSHRS; i++) begin
      free[i]      = !status[i].busy;
      idx_match[i] = status[i].busy && (status[i].block_addr[mshr_pkg::IDX_BITS-1:0] ==
                                        req_block[mshr_pkg::IDX_BITS-1:0]);
      blk_match[i] = status[i].busy && (status[i].block_addr == req_block);
      sec_open[i]  = blk_match[i] && status[i].sec_rdy;
    end
  end

  assign lowest_free = free & (~free + 1'b1);  // Lowest free entry only

  assign block_hit    = cacheable && (|blk_match);
  assign set_conflict = cacheable && (|(idx_match & ~blk_match));

  assign sdq_ok = !req.is_write || sdq_has_free;
  assign pri_ok = !(|idx_match) && (|free);
  assign sec_ok = |sec_open;  // At most one entry holds the block

  assign req_ready = cacheable && sdq_ok && (pri_ok || sec_ok);
  assign req_fire  = req_valid && req_ready;

  assign pri_alloc = lowest_free & {mshr_pkg::NUM_MSHRS{req_fire && pri_ok}};
  assign sec_alloc = sec_open & {mshr_pkg::NUM_MSHRS{req_fire}};
  assign sdq_enq   = req_fire && req.is_write;

endmodule

`default_nettype wire

// ==== verilog/mshr_entry.sv ====
`timescale 1ns/1ps
`default_nettype none

module mshr_entry #(
  parameter int ENTRY_ID = 0
) (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               pri_alloc,
  input  wire logic               sec_alloc,
  input  wire mshr_pkg::mem_req_t req,
  input  wire mshr_pkg::sdq_id_t  sdq_alloc_id,
  input  wire logic               acquire_ready,
  input  wire logic               grant_valid,
  input  wire mshr_pkg::mshr_id_t grant_id,
  input  wire logic               replay_ready,
  output mshr_pkg::entry_status_t status,
  output logic                    acquire_valid,
  output mshr_pkg::acquire_t      acquire,
  output logic                    replay_valid,
  output mshr_pkg::replay_req_t   replay
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_ACQUIRE,
    S_WAIT_GRANT,
    S_REPLAY
  } state_t;

  state_t state;
  logic [mshr_pkg::BLOCK_W-1:0] block_addr;
  mshr_pkg::replay_req_t rpq [mshr_pkg::RPQ_DEPTH];
  logic [$clog2(mshr_pkg::RPQ_DEPTH)-1:0] head;
  logic [$clog2(mshr_pkg::RPQ_DEPTH)-1:0] tail;
  logic [$clog2(mshr_pkg::RPQ_DEPTH+1)-1:0] count;
  logic push;
  logic pop;
  logic my_grant;

  assign push     = pri_alloc || sec_alloc;
  assign pop      = replay_valid && replay_ready;
  assign my_grant = grant_valid && (grant_id == mshr_pkg::mshr_id_t'(ENTRY_ID));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= S_IDLE;
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      case (state)
        S_IDLE:       if (pri_alloc) state <= S_ACQUIRE;
        S_ACQUIRE:    if (acquire_ready) state <= S_WAIT_GRANT;
        S_WAIT_GRANT: if (my_grant) state <= S_REPLAY;
        S_REPLAY:     if (pop && count == 1) state <= S_IDLE;  // Last request out
        default:      state <= S_IDLE;
      endcase
      if (push) tail <= tail + 1'b1;
      if (pop) head <= head + 1'b1;
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (pri_alloc) block_addr <= req.addr[mshr_pkg::ADDR_W-1:mshr_pkg::BLOCK_OFF_BITS];
    if (push) begin
      rpq[tail] <= '{addr: req.addr, is_write: req.is_write, req_id: req.req_id,
                     sdq_id: sdq_alloc_id};
    end
  end

  assign acquire_valid = (state == S_ACQUIRE);
  assign acquire       = '{block_addr: block_addr, mshr_id: mshr_pkg::mshr_id_t'(ENTRY_ID)};
  assign replay_valid  = (state == S_REPLAY);
  assign replay        = rpq[head];

  // No secondary once replay starts, so the list only drains there
  assign status = '{busy: (state != S_IDLE),
                    block_addr: block_addr,
                    sec_rdy: (state == S_ACQUIRE || state == S_WAIT_GRANT) &&
                             (int'(count) < mshr_pkg::RPQ_DEPTH)};

endmodule

`default_nettype wire

// ==== verilog/mshr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module mshr_file (
  input  wire logic               clock,
  input  wire logic               reset,
  input  wire logic               req_valid,
  input  wire mshr_pkg::mem_req_t req,
  output logic                    req_ready,
  output logic                    block_hit,
  output logic                    set_conflict,
  output logic                    acquire_valid,
  output mshr_pkg::acquire_t      acquire,
  input  wire logic               acquire_ready,
  input  wire logic               grant_valid,
  input  wire mshr_pkg::mshr_id_t grant_id,
  output logic                    replay_valid,
  output mshr_pkg::replay_t       replay,
  input  wire logic               replay_ready
);

  mshr_pkg::entry_status_t status [mshr_pkg::NUM_MSHRS];
  logic [mshr_pkg::NUM_MSHRS-1:0] pri_alloc;
  logic [mshr_pkg::NUM_MSHRS-1:0] sec_alloc;
  logic sdq_enq;
  logic sdq_has_free;
  mshr_pkg::sdq_id_t sdq_alloc_id;
  logic [mshr_pkg::DATA_W-1:0] sdq_rd_data;
  logic [mshr_pkg::NUM_MSHRS-1:0] acq_valid;
  logic [mshr_pkg::NUM_MSHRS-1:0] acq_ready;
  mshr_pkg::acquire_t acq_bits [mshr_pkg::NUM_MSHRS];
  logic [mshr_pkg::NUM_MSHRS-1:0] rep_valid;
  logic [mshr_pkg::NUM_MSHRS-1:0] rep_ready;
  mshr_pkg::replay_req_t rep_bits [mshr_pkg::NUM_MSHRS];
  mshr_pkg::replay_req_t rep_out;

  mshr_alloc_ctrl u_alloc_ctrl (
    .req_valid    (req_valid),
    .req          (req),
    .status       (status),
    .sdq_has_free (sdq_has_free),
    .req_ready    (req_ready),
    .pri_alloc    (pri_alloc),
    .sec_alloc    (sec_alloc),
    .sdq_enq      (sdq_enq),
    .block_hit    (block_hit),
    .set_conflict (set_conflict)
  );

  store_data_queue u_sdq (
    .clock       (clock),
    .reset       (reset),
    .enq         (sdq_enq),
    .enq_data    (req.data),
    .replay_fire (replay_valid && replay_ready),
    .replay      (rep_out),
    .has_free    (sdq_has_free),
    .alloc_id    (sdq_alloc_id),
    .rd_data     (sdq_rd_data)
  );

  for (genvar i = 0; i < mshr_pkg::NUM_MSHRS; i++) begin : g_entry
    mshr_entry #(.ENTRY_ID(i)) u_entry (
      .clock         (clock),
      .reset         (reset),
      .pri_alloc     (pri_alloc[i]),
      .sec_alloc     (sec_alloc[i]),
      .req           (req),
      .sdq_alloc_id  (sdq_alloc_id),
      .acquire_ready (acq_ready[i]),
      .grant_valid   (grant_valid),
      .grant_id      (grant_id),
      .replay_ready  (rep_ready[i]),
      .status        (status[i]),
      .acquire_valid (acq_valid[i]),
      .acquire       (acq_bits[i]),
      .replay_valid  (rep_valid[i]),
      .replay        (rep_bits[i])
    );
  end

  fixed_arbiter #(.payload_t(mshr_pkg::acquire_t)) u_acquire_arb (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (acq_valid),
    .in_bits   (acq_bits),
    .out_ready (acquire_ready),
    .in_ready  (acq_ready),
    .out_valid (acquire_valid),
    .out_bits  (acquire)
  );

  fixed_arbiter #(.payload_t(mshr_pkg::replay_req_t)) u_replay_arb (
    .clock     (clock),
    .reset     (reset),
    .in_valid  (rep_valid),
    .in_bits   (rep_bits),
    .out_ready (replay_ready),
    .in_ready  (rep_ready),
    .out_valid (replay_valid),
    .out_bits  (rep_out)
  );

  assign replay = '{req: rep_out, data: sdq_rd_data};  // Store data joins at the output

endmodule

`default_nettype wire

// ==== verilog/mshr_pkg.sv ====
`default_nettype none

package mshr_pkg;

  localparam int NUM_MSHRS      = 4;
  localparam int NUM_SDQ        = 4;
  localparam int RPQ_DEPTH      = 2;
  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 64;
  localparam int BLOCK_OFF_BITS = 6;
  localparam int IDX_BITS       = 6;
  localparam int REQ_ID_W       = 4;
  localparam int BLOCK_W        = ADDR_W - BLOCK_OFF_BITS;  // Tag plus index

  // Cacheable regions, everything else is uncacheable
  localparam logic [ADDR_W-1:0] CACHE_BASE_0 = 32'h1000_0000;
  localparam logic [ADDR_W-1:0] CACHE_MASK_0 = 32'hff00_0000;  // 16 MB
  localparam logic [ADDR_W-1:0] CACHE_BASE_1 = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] CACHE_MASK_1 = 32'hf000_0000;  // 256 MB

  typedef logic [1:0] mshr_id_t;
  typedef logic [1:0] sdq_id_t;

  typedef struct packed {
    logic [ADDR_W-1:0]   addr;
    logic                is_write;
    logic [DATA_W-1:0]   data;
    logic [REQ_ID_W-1:0] req_id;
  } mem_req_t;

  typedef struct packed {
    logic               busy;
    logic [BLOCK_W-1:0] block_addr;
    logic               sec_rdy;  // Can still take a secondary miss
  } entry_status_t;

  typedef struct packed {
    logic [ADDR_W-1:0]   addr;
    logic                is_write;
    logic [REQ_ID_W-1:0] req_id;
    sdq_id_t             sdq_id;
  } replay_req_t;

  typedef struct packed {
    replay_req_t       req;
    logic [DATA_W-1:0] data;
  } replay_t;

  typedef struct packed {
    logic [BLOCK_W-1:0] block_addr;
    mshr_id_t           mshr_id;
  } acquire_t;

endpackage

`default_nettype wire

// ==== verilog/store_data_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_data_queue (
  input  wire logic                        clock,
  input  wire logic                        reset,
  input  wire logic                        enq,
  input  wire logic [mshr_pkg::DATA_W-1:0] enq_data,
  input  wire logic                        replay_fire,
  input  wire mshr_pkg::replay_req_t       replay,
  output logic                             has_free,
  output mshr_pkg::sdq_id_t                alloc_id,
  output logic [mshr_pkg::DATA_W-1:0]      rd_data
);

  logic [mshr_pkg::NUM_SDQ-1:0] slot_valid;
  logic [mshr_pkg::DATA_W-1:0] slot_data [mshr_pkg::NUM_SDQ];

  always_comb begin
    alloc_id = '0;
    for (int i = mshr_pkg::NUM_SDQ - 1; i >= 0; i--) begin
      if (!slot_valid[i]) begin
        alloc_id = mshr_pkg::sdq_id_t'(i);
      end
    end
  end

  assign has_free = !(&slot_valid);
  assign rd_data  = replay.is_write ? slot_data[replay.sdq_id] : '0;  // Zero for reads

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      slot_valid <= '0;
    end else begin
      if (replay_fire && replay.is_write) slot_valid[replay.sdq_id] <= 1'b0;
      if (enq) slot_valid[alloc_id] <= 1'b1;  // Never the slot being freed
    end
  end

  always_ff @(posedge clock) begin
    if (enq) slot_data[alloc_id] <= enq_data;
  end

endmodule

`default_nettype wire
